// File: verilog/led_consts.svh
`ifndef LED_CONSTS_SVH
`define LED_CONSTS_SVH

// strand geometry
`define NUM_STRANDS 4
`define NUM_LEDS 4

// bits per colour channel
`define COLOR_WIDTH 8

// serial bit timing, in 100 MHz clock cycles
// high time of a 0 bit (350 ns)
`define T0H 35
// high time of a 1 bit (700 ns)
`define T1H 70
// full bit period (1.25 us)
`define TBIT 125

// low time after the last bit before the strand latches (50 us)
`define TLATCH 5000

`endif

// File: verilog/led_pkg.sv
`default_nettype none

`include "led_consts.svh"

package led_pkg;

    // one colour channel
    typedef logic [`COLOR_WIDTH-1:0] color_t;

    // wire order of one LED, green goes out first, MSB first
    typedef struct packed {
        color_t green;
        color_t red;
        color_t blue;
    } grb_t;

    // position of an LED inside its strand
    typedef logic [$clog2(`NUM_LEDS)-1:0] led_idx_t;

    // which strand a request came from
    typedef logic [$clog2(`NUM_STRANDS)-1:0] strand_id_t;

endpackage

`default_nettype wire

// File: verilog/pattern_pkg.sv
`default_nettype none

package pattern_pkg;

    // pattern select, straight from sw[15:14]
    typedef enum logic [1:0] {
        // everything dark
        pat_off      = 2'd0,
        // all channels at the brightness
        pat_solid    = 2'd1,
        // red rises, green falls along the strands, blue follows the frame
        pat_gradient = 2'd2,
        // one lit LED per strand stepping each frame
        pat_chase    = 2'd3
    } pattern_mode_e;

    // completed frame count, also shown on the board LEDs
    typedef logic [15:0] frame_cnt_t;

endpackage

`default_nettype wire

// File: verilog/pattern_source.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_consts.svh"

module pattern_source (
    input  logic                      clk_in,
    input  logic                      reset,
    input  pattern_pkg::pattern_mode_e mode,
    input  led_pkg::color_t           brightness,
    input  pattern_pkg::frame_cnt_t   frame_cnt,
    input  logic                      color_req [`NUM_STRANDS],
    input  led_pkg::led_idx_t         req_idx [`NUM_STRANDS],
    output led_pkg::grb_t             color_word,
    output logic                      color_valid [`NUM_STRANDS]
);

    import led_pkg::*;
    import pattern_pkg::*;

    // strands still waiting for a word
    logic [`NUM_STRANDS-1:0] pending;

    // last strand served, search starts just after it
    strand_id_t last_id;

    // winner of this cycle
    logic       grant_found;
    strand_id_t grant_id;
    led_idx_t   grant_idx;

    // global LED number, strand id above the index
    logic [$bits(strand_id_t)+$bits(led_idx_t)-1:0] led_num;

    // colour for the winner, registered below
    grb_t   next_word;
    color_t grad_red;
    led_idx_t chase_pos;

    // a strand whose valid is out this cycle drops its request next cycle,
    // so it must not win again now
    always_comb begin
        for (int i = 0; i < `NUM_STRANDS; i++) begin
            pending[i] = color_req[i] & ~color_valid[i];
        end
    end

    // rotating priority, first pending strand after last_id wins
    always_comb begin
        grant_found = 1'b0;
        grant_id    = last_id;
        for (int i = 1; i <= `NUM_STRANDS; i++) begin
            if (!grant_found && pending[strand_id_t'(last_id + i)]) begin
                grant_found = 1'b1;
                grant_id    = strand_id_t'(last_id + i);
            end
        end
    end

    assign grant_idx = req_idx[grant_id];
    assign led_num   = {grant_id, grant_idx};

    // 16 per LED step along the whole chain
    assign grad_red  = color_t'(led_num) << 4;
    // lit position for chase, same on every strand
    assign chase_pos = led_idx_t'(frame_cnt % `NUM_LEDS);

    // mode rule for the winning strand and index
    always_comb begin
        next_word = '0;
        case (mode)
            pat_solid: begin
                next_word.green = brightness;
                next_word.red   = brightness;
                next_word.blue  = brightness;
            end
            pat_gradient: begin
                next_word.red   = grad_red;
                next_word.green = color_t'('1) - grad_red;
                next_word.blue  = color_t'(frame_cnt);
            end
            pat_chase: begin
                if (grant_idx == chase_pos) begin
                    next_word.green = brightness;
                    next_word.red   = brightness;
                    next_word.blue  = brightness;
                end
            end
            default: next_word = '0;
        endcase
    end

    // colour word is shared by all strands
    always_ff @(posedge clk_in) begin
        if (grant_found) begin
            color_word <= next_word;
        end
    end

    // one-hot valid back to the served strand only
    always_ff @(posedge clk_in) begin
        if (reset) begin
            last_id <= '0;
            for (int i = 0; i < `NUM_STRANDS; i++) begin
                color_valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `NUM_STRANDS; i++) begin
                color_valid[i] <= grant_found && (grant_id == strand_id_t'(i));
            end
            if (grant_found) begin
                last_id <= grant_id;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/led_driver.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_consts.svh"

module led_driver (
    input  logic              clk_in,
    input  logic              reset,
    input  logic              frame_start,
    input  logic              force_restart,
    output logic              color_req,
    output led_pkg::led_idx_t req_idx,
    input  led_pkg::grb_t     color_word,
    input  logic              color_valid,
    output logic              strand_out,
    output logic              frame_done
);

    import led_pkg::*;

    // counter covers the latch gap, the bit period fits easily
    localparam int phase_w = $clog2(`TLATCH);
    localparam int grb_bits = $bits(grb_t);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_latch
    } state_t;

    state_t state;

    // word on the wire, MSB goes out first
    grb_t shift_reg;
    logic [4:0] bit_cnt;
    logic [phase_w-1:0] phase_cnt;
    // LED currently being shifted
    led_idx_t led_cnt;
    led_idx_t next_led;

    // prefetched word for the following LED
    grb_t buf_word;
    logic buf_full;

    // high time of the bit now on the wire
    logic [phase_w-1:0] high_time;

    assign high_time = shift_reg[grb_bits-1] ? phase_w'(`T1H) : phase_w'(`T0H);
    assign next_led  = led_cnt + 1'b1;

    // prefetch buffer payload
    always_ff @(posedge clk_in) begin
        if (color_valid && color_req) begin
            buf_word <= color_word;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= st_idle;
            color_req  <= 1'b0;
            req_idx    <= '0;
            buf_full   <= 1'b0;
            phase_cnt  <= '0;
            bit_cnt    <= '0;
            led_cnt    <= '0;
            strand_out <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            // line is high only in the first part of each bit
            strand_out <= (state == st_shift) && (phase_cnt < high_time);

            // word came back, request drops next cycle
            if (color_valid && color_req) begin
                buf_full  <= 1'b1;
                color_req <= 1'b0;
            end

            if (force_restart) begin
                // abort whatever is in flight and hold the line low
                state     <= st_latch;
                phase_cnt <= '0;
                color_req <= 1'b0;
                buf_full  <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        if (frame_start) begin
                            // fetch LED 0 before anything goes out
                            color_req <= 1'b1;
                            req_idx   <= '0;
                        end else if (buf_full) begin
                            shift_reg <= buf_word;
                            buf_full  <= 1'b0;
                            phase_cnt <= '0;
                            bit_cnt   <= '0;
                            led_cnt   <= '0;
                            state     <= st_shift;
                            // LED 1 is fetched while LED 0 shifts
                            if (`NUM_LEDS > 1) begin
                                color_req <= 1'b1;
                                req_idx   <= led_idx_t'(1);
                            end
                        end
                    end

                    st_shift: begin
                        if (phase_cnt == phase_w'(`TBIT - 1)) begin
                            phase_cnt <= '0;
                            if (bit_cnt == 5'(grb_bits - 1)) begin
                                if (led_cnt == led_idx_t'(`NUM_LEDS - 1)) begin
                                    // last bit of the strand done
                                    state <= st_latch;
                                end else begin
                                    // next LED follows with no gap
                                    shift_reg <= buf_word;
                                    buf_full  <= 1'b0;
                                    bit_cnt   <= '0;
                                    led_cnt   <= next_led;
                                    if (next_led != led_idx_t'(`NUM_LEDS - 1)) begin
                                        color_req <= 1'b1;
                                        req_idx   <= next_led + 1'b1;
                                    end
                                end
                            end else begin
                                bit_cnt   <= bit_cnt + 1'b1;
                                shift_reg <= grb_t'({shift_reg[grb_bits-2:0], 1'b0});
                            end
                        end else begin
                            phase_cnt <= phase_cnt + 1'b1;
                        end
                    end

                    st_latch: begin
                        // strand latches after the low gap
                        if (phase_cnt == phase_w'(`TLATCH - 1)) begin
                            phase_cnt  <= '0;
                            frame_done <= 1'b1;
                            state      <= st_idle;
                        end else begin
                            phase_cnt <= phase_cnt + 1'b1;
                        end
                    end

                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/frame_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_consts.svh"

module frame_scheduler (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    frame_done [`NUM_STRANDS],
    output logic                    frame_start,
    output pattern_pkg::frame_cnt_t frame_cnt
);

    // sticky done per strand for the current frame
    logic [`NUM_STRANDS-1:0] done_flags;
    // flags including this cycle's pulses
    logic [`NUM_STRANDS-1:0] done_next;
    logic all_done;

    // first frame goes out right after reset
    logic started;

    always_comb begin
        for (int i = 0; i < `NUM_STRANDS; i++) begin
            done_next[i] = done_flags[i] | frame_done[i];
        end
    end

    // every strand in, start the next frame on the following cycle
    assign all_done = &done_next;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            done_flags  <= '0;
            frame_start <= 1'b0;
            frame_cnt   <= '0;
            started     <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (!started) begin
                started     <= 1'b1;
                frame_start <= 1'b1;
                done_flags  <= '0;
            end else if (all_done) begin
                // an aborted frame counts too
                frame_start <= 1'b1;
                frame_cnt   <= frame_cnt + 1'b1;
                done_flags  <= '0;
            end else begin
                done_flags <= done_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/top_level.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_consts.svh"

module top_level (
    input  wire         clk_100mhz,
    // btn[0] reset, btn[1] force restart
    input  wire  [3:0]  btn,
    // sw[15:14] pattern, sw[7:0] brightness
    input  wire  [15:0] sw,
    // green board LEDs show the frame count
    output logic [15:0] led,
    output logic [2:0]  rgb0,
    output logic [2:0]  rgb1,
    // one serial line per strand, on PMODA
    output logic [3:0]  strand_out
);

    import led_pkg::*;
    import pattern_pkg::*;

    logic reset;
    logic force_restart;

    pattern_mode_e mode;
    color_t        brightness;
    frame_cnt_t    frame_cnt;

    // frame control
    logic frame_start;
    logic frame_done [`NUM_STRANDS];

    // colour request path between the drivers and the source
    logic     color_req [`NUM_STRANDS];
    led_idx_t req_idx [`NUM_STRANDS];
    logic     color_valid [`NUM_STRANDS];
    grb_t     color_word;

    // RGB board LEDs unused, keep them dark
    assign rgb0 = 3'b000;
    assign rgb1 = 3'b000;

    assign reset         = btn[0];
    assign force_restart = btn[1];
    assign mode          = pattern_mode_e'(sw[15:14]);
    assign brightness    = color_t'(sw[7:0]);

    assign led = frame_cnt;

    // one colour server for all strands
    pattern_source u_pattern (
        .clk_in      (clk_100mhz),
        .reset       (reset),
        .mode        (mode),
        .brightness  (brightness),
        .frame_cnt   (frame_cnt),
        .color_req   (color_req),
        .req_idx     (req_idx),
        .color_word  (color_word),
        .color_valid (color_valid)
    );

    // identical strand drivers
    for (genvar s = 0; s < `NUM_STRANDS; s++) begin : g_strand
        led_driver u_driver (
            .clk_in        (clk_100mhz),
            .reset         (reset),
            .frame_start   (frame_start),
            .force_restart (force_restart),
            .color_req     (color_req[s]),
            .req_idx       (req_idx[s]),
            .color_word    (color_word),
            .color_valid   (color_valid[s]),
            .strand_out    (strand_out[s]),
            .frame_done    (frame_done[s])
        );
    end

    // frame start and count
    frame_scheduler u_scheduler (
        .clk_in      (clk_100mhz),
        .reset       (reset),
        .frame_done  (frame_done),
        .frame_start (frame_start),
        .frame_cnt   (frame_cnt)
    );

endmodule

`default_nettype wire

// File: dv/led_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_consts.svh"

module led_sva (
    input logic clk_in,
    input logic reset,
    input logic force_restart,
    input logic frame_start,
    input logic color_req,
    input logic color_valid,
    input logic strand_out,
    input logic frame_done
);

    // consecutive high and low samples of the line
    int   hi_cnt;
    int   lo_cnt;
    // set from an abort until the next frame begins
    logic aborted;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            hi_cnt  <= 0;
            lo_cnt  <= 0;
            aborted <= 1'b0;
        end else begin
            if (strand_out) begin
                hi_cnt <= hi_cnt + 1;
                lo_cnt <= 0;
            end else begin
                hi_cnt <= 0;
                lo_cnt <= lo_cnt + 1;
            end
            if (force_restart) begin
                aborted <= 1'b1;
            end else if (frame_start) begin
                aborted <= 1'b0;
            end
        end
    end

    // request held until served
    req_held: assert property (@(posedge clk_in) disable iff (reset)
        color_req && !color_valid && !force_restart |=> color_req)
        else $error("color_req dropped before its color_valid");

    // a cut pulse after an abort is expected
    pulse_width: assert property (@(posedge clk_in) disable iff (reset)
        $fell(strand_out) && !aborted |-> (hi_cnt == `T0H || hi_cnt == `T1H))
        else $error("strand high pulse of %0d cycles", hi_cnt);

    // an abort can leave the line high for one more cycle
    latch_gap: assert property (@(posedge clk_in) disable iff (reset)
        frame_done |-> lo_cnt >= (aborted ? `TLATCH - 1 : `TLATCH))
        else $error("frame_done after only %0d low cycles", lo_cnt);

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_consts.svh"

module tb_top;

    import led_pkg::*;
    import pattern_pkg::*;

    localparam int word_slots = 64;
    // high time above this decodes as a 1
    localparam int bit_threshold = (`T0H + `T1H) / 2;
    localparam int frame_cycles = `NUM_LEDS * 24 * `TBIT + `TLATCH + 100;

    logic        clk;
    logic [3:0]  btn;
    logic [15:0] sw;
    logic [15:0] led;
    logic [2:0]  rgb0;
    logic [2:0]  rgb1;
    logic [3:0]  strand_out;

    // decoder state per strand
    int   hi_cnt [`NUM_STRANDS];
    int   lo_cnt [`NUM_STRANDS];
    int   nbits [`NUM_STRANDS];
    int   bits_total [`NUM_STRANDS];
    int   words_total [`NUM_STRANDS];
    int   base [`NUM_STRANDS];
    grb_t shreg [`NUM_STRANDS];
    grb_t words [`NUM_STRANDS][word_slots];

    int         errors;
    time        deadline;
    logic [7:0] lfsr_state;

    top_level u_dut (
        .clk_100mhz (clk),
        .btn        (btn),
        .sw         (sw),
        .led        (led),
        .rgb0       (rgb0),
        .rgb1       (rgb1),
        .strand_out (strand_out)
    );

    bind led_driver led_sva u_sva (
        .clk_in        (clk_in),
        .reset         (reset),
        .force_restart (force_restart),
        .frame_start   (frame_start),
        .color_req     (color_req),
        .color_valid   (color_valid),
        .strand_out    (strand_out),
        .frame_done    (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // strand decoders sampled mid-cycle
    always @(negedge clk) begin
        for (int s = 0; s < `NUM_STRANDS; s++) begin
            if (strand_out[s] === 1'b1) begin
                hi_cnt[s] = hi_cnt[s] + 1;
                lo_cnt[s] = 0;
            end else begin
                if (hi_cnt[s] != 0) begin
                    shreg[s] = grb_t'({shreg[s][22:0], hi_cnt[s] > bit_threshold});
                    nbits[s] = nbits[s] + 1;
                    bits_total[s] = bits_total[s] + 1;
                    if (nbits[s] == 24) begin
                        words[s][words_total[s] % word_slots] = shreg[s];
                        words_total[s] = words_total[s] + 1;
                        nbits[s] = 0;
                    end
                end
                hi_cnt[s] = 0;
                lo_cnt[s] = lo_cnt[s] + 1;
                // long low resyncs to a word boundary
                if (lo_cnt[s] > `TBIT) begin
                    nbits[s] = 0;
                end
            end
        end
    end

    // hang guard whose deadline moves with each test
    initial begin
        do begin
            @(posedge clk);
        end while ($time <= deadline);
        $display("watchdog expired, the run hung");
        $display("Test failed");
        $finish;
    end

    // taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // rotate left one byte within 24 bits, then fold in the word
    function automatic logic [31:0] fold_sum(input logic [31:0] sum, input grb_t w);
        logic [23:0] r;
        r = {sum[15:0], sum[23:16]};
        return {8'h00, r ^ w};
    endfunction

    function automatic grb_t expected_word(input pattern_mode_e m, input color_t br,
                                           input int s, input int i, input frame_cnt_t c);
        grb_t w;
        int   g;
        w = '0;
        g = s * `NUM_LEDS + i;
        case (m)
            pat_solid: begin
                w.green = br;
                w.red   = br;
                w.blue  = br;
            end
            pat_gradient: begin
                w.red   = color_t'(16 * g);
                w.green = color_t'(255 - 16 * g);
                w.blue  = c[7:0];
            end
            pat_chase: begin
                if (i == int'(c) % `NUM_LEDS) begin
                    w.green = br;
                    w.red   = br;
                    w.blue  = br;
                end
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic check_grb(input string name, input grb_t exp, input grb_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_frame(input string name, input frame_cnt_t exp, input frame_cnt_t act);
        if (exp !== act) begin
            $display("Error %s frame count: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_sum(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s checksum: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rgb(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // returns 1 ns after the edge where led moved
    task automatic wait_frame_end();
        logic [15:0] prev;
        prev = led;
        do begin
            @(posedge clk);
            #1;
        end while (led == prev);
    endtask

    task automatic mark_frame();
        for (int s = 0; s < `NUM_STRANDS; s++) begin
            base[s] = words_total[s];
        end
    endtask

    task automatic check_frame_words(input string name, input pattern_mode_e m,
                                     input color_t br, input frame_cnt_t c,
                                     input logic [31:0] file_sum, input bit first);
        logic [31:0] got_sum;
        logic [31:0] exp_sum;
        grb_t        exp_w;
        grb_t        got_w;
        int          n;
        got_sum = '0;
        exp_sum = '0;
        for (int s = 0; s < `NUM_STRANDS; s++) begin
            n = words_total[s] - base[s];
            if (n != `NUM_LEDS) begin
                $display("Error %s strand %0d words in frame %0d: expected %0d, actual %0d",
                         name, s, c, `NUM_LEDS, n);
                errors++;
            end
            for (int i = 0; i < `NUM_LEDS; i++) begin
                exp_w = expected_word(m, br, s, i, c);
                got_w = words[s][(base[s] + i) % word_slots];
                check_grb($sformatf("%s s%0d led%0d f%0d", name, s, i, c), exp_w, got_w);
                got_sum = fold_sum(got_sum, got_w);
                exp_sum = fold_sum(exp_sum, exp_w);
            end
        end
        if (first) begin
            check_sum(name, file_sum, got_sum);
        end else begin
            check_sum(name, exp_sum, got_sum);
        end
    endtask

    initial begin
        int          fd;
        int          n_read;
        int          mode_v;
        int          br_v;
        int          frames_v;
        int          restart_v;
        int          expected_frames;
        int          err_start;
        int          tests;
        int          failed;
        int          bits_snap [`NUM_STRANDS];
        logic [31:0] sum_v;
        color_t      br;
        frame_cnt_t  c;
        string       line;
        string       name;

        btn = 4'b0001;
        sw = '0;
        errors = 0;
        tests = 0;
        failed = 0;
        expected_frames = 0;
        lfsr_state = 8'd90;
        deadline = 64'd200000;
        for (int s = 0; s < `NUM_STRANDS; s++) begin
            hi_cnt[s] = 0;
            lo_cnt[s] = 0;
            nbits[s] = 0;
            bits_total[s] = 0;
            words_total[s] = 0;
            base[s] = 0;
            shreg[s] = '0;
        end

        repeat (5) @(posedge clk);
        #1;
        btn[0] = 1'b0;

        fd = $fopen("dv/led_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/led_patterns.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n_read = $sscanf(line, "%s %d %h %d %d %h",
                                 name, mode_v, br_v, frames_v, restart_v, sum_v);
                if (n_read != 6) begin
                    $display("malformed test line: %s", line);
                    errors++;
                    continue;
                end
                err_start = errors;
                tests++;
                deadline = $time + 64'(frames_v + 3) * 64'(frame_cycles) * 64'd10 + 64'd10000;

                br = color_t'(br_v);
                if (br_v > 255) begin
                    for (int b = 0; b < 8; b++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        br = {br[6:0], lfsr_state[0]};
                    end
                end
                // new settings land before the next frame's first fetch
                sw[15:14] = mode_v[1:0];
                sw[7:0] = br;

                wait_frame_end();
                mark_frame();

                if (restart_v != 0) begin
                    // abort somewhere inside LED 0 or 1
                    repeat (3000) @(posedge clk);
                    #1;
                    btn[1] = 1'b1;
                    @(posedge clk);
                    #1;
                    btn[1] = 1'b0;
                    repeat (3) @(posedge clk);
                    #1;
                    for (int s = 0; s < `NUM_STRANDS; s++) begin
                        bits_snap[s] = bits_total[s];
                    end
                    wait_frame_end();
                    for (int s = 0; s < `NUM_STRANDS; s++) begin
                        if (bits_total[s] != bits_snap[s]) begin
                            $display("%s: strand %0d kept sending bits after the restart",
                                     name, s);
                            errors++;
                        end
                    end
                    mark_frame();
                end

                for (int f = 0; f < frames_v; f++) begin
                    // frames finished before this one
                    c = frame_cnt_t'(expected_frames + 1 + restart_v + f);
                    wait_frame_end();
                    check_frame_words(name, pattern_mode_e'(mode_v[1:0]), br, c, sum_v,
                                      f == 0);
                    mark_frame();
                end

                expected_frames = expected_frames + frames_v + 1 + restart_v;
                check_frame(name, frame_cnt_t'(expected_frames), frame_cnt_t'(led));
                check_rgb($sformatf("%s rgb0", name), 3'b000, rgb0);
                check_rgb($sformatf("%s rgb1", name), 3'b000, rgb1);

                if (errors == err_start) begin
                    $display("test %s: pass", name);
                end else begin
                    failed++;
                    $display("test %s: FAIL, %0d errors", name, errors - err_start);
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests, tests - failed, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/led_pkg.sv
verilog/pattern_pkg.sv
verilog/pattern_source.sv
verilog/led_driver.sv
verilog/frame_scheduler.sv
verilog/top_level.sv
dv/led_sva.sv
dv/tb_top.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_top
RTL_TOP    = top_level
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides, the simulator exit code is not trusted
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/led_patterns.txt
# name mode(0 off, 1 solid, 2 gradient, 3 chase) brightness(hex, 100 = lfsr) frames restart
# last column is the checksum of the first checked frame, hex
off         0 00  1 0 00000000
solid_file  1 3c  1 0 00000000
solid_lfsr  1 100 1 0 00000000
gradient    2 00  2 0 0057580f
chase       3 80  4 0 00000000
restart     1 21  1 1 00000000
